// ==== logic/clock_lcd_pkg.sv ====
// Clock LCD shared definitions
`default_nettype none

package clock_lcd_pkg;

    typedef logic [3:0] bcd_digit_t;
    typedef logic [7:0] lcd_char_t;
    typedef logic [4:0] char_index_t;  // 0-15 line 1, 16-31 line 2

    typedef enum logic [5:0] {
        clock_view       = 6'b000000,
        clock_edit_idle  = 6'b010000,
        clock_edit_hour  = 6'b010011,
        clock_edit_min   = 6'b010101,
        clock_edit_sec   = 6'b010111,
        clock_edit_year  = 6'b011011,
        clock_edit_month = 6'b011101,
        clock_edit_day   = 6'b011111,
        alarm_view       = 6'b100001,
        alarm_edit_idle  = 6'b110001,
        alarm_edit_hour  = 6'b110011,
        alarm_edit_min   = 6'b110101,
        alarm_edit_sec   = 6'b110111
    } display_mode_e;

    typedef enum logic [2:0] {
        power_up,
        function_set,
        display_on,
        entry_mode,
        line1,
        line2,
        return_home
    } lcd_state_e;

    localparam int SCREEN_CHARS      = 32;
    localparam int LINE_CHARS        = 16;
    localparam int POWER_UP_CYCLES   = 70;
    localparam int COMMAND_CYCLES    = 30;
    localparam int WRITE_CYCLES      = 4;
    localparam int BLINK_HALF_PERIOD = 500;
    localparam int BLINK_TOGGLES     = 20;  // even, so the field ends visible

    localparam int BLINK_HALF_W   = $clog2(BLINK_HALF_PERIOD);
    localparam int BLINK_TOGGLE_W = $clog2(BLINK_TOGGLES + 1);
    localparam int STEP_W         = $clog2(POWER_UP_CYCLES);  // longest step count
    localparam int SLOT_W         = $clog2(WRITE_CYCLES);

    localparam lcd_char_t CHAR_SPACE = 8'h20;
    localparam lcd_char_t CHAR_COLON = 8'h3A;
    localparam lcd_char_t CHAR_ZERO  = 8'h30;
    localparam lcd_char_t CHAR_TWO   = 8'h32;
    localparam lcd_char_t CHAR_Y     = 8'h59;
    localparam lcd_char_t CHAR_M     = 8'h4D;
    localparam lcd_char_t CHAR_D     = 8'h44;
    localparam lcd_char_t CHAR_NOTE  = 8'h91;  // panel rom glyph
    localparam lcd_char_t CHAR_BELL  = 8'h98;  // panel rom glyph
    localparam lcd_char_t CHAR_EDIT  = 8'hA9;  // panel rom glyph

    localparam lcd_char_t CMD_FUNCTION_SET = 8'h3C;  // 8-bit bus, 2 lines
    localparam lcd_char_t CMD_DISPLAY_ON   = 8'h0C;  // no cursor
    localparam lcd_char_t CMD_ENTRY_MODE   = 8'h06;  // increment, no shift
    localparam lcd_char_t CMD_LINE1_ADDR   = 8'h80;
    localparam lcd_char_t CMD_LINE2_ADDR   = 8'hC0;
    localparam lcd_char_t CMD_RETURN_HOME  = 8'h02;

endpackage

`default_nettype wire

// ==== logic/field_blinker.sv ====
// Edited field blink timer
`default_nettype none

module field_blinker
(
    input  logic CLK,
    input  logic RESETN,
    input  logic editing,
    input  logic blink_restart,
    output logic blink_phase
);
    import clock_lcd_pkg::*;

    logic [BLINK_HALF_W-1:0]   half_cnt;
    logic [BLINK_TOGGLE_W-1:0] toggle_cnt;
    logic                      half_end;
    logic                      toggles_done;

    assign half_end     = (half_cnt == BLINK_HALF_W'(BLINK_HALF_PERIOD - 1));
    assign toggles_done = (toggle_cnt == BLINK_TOGGLE_W'(BLINK_TOGGLES));

    always_ff @(posedge CLK)
    begin
        if (!RESETN)
        begin
            half_cnt    <= '0;
            toggle_cnt  <= '0;
            blink_phase <= 1'b0;
        end
        else if (!editing || blink_restart)
        begin
            half_cnt    <= '0;  // new session or edit left
            toggle_cnt  <= '0;
            blink_phase <= 1'b0;
        end
        else if (!toggles_done)
        begin
            if (half_end)
            begin
                half_cnt    <= '0;
                toggle_cnt  <= toggle_cnt + 1'b1;
                blink_phase <= ~blink_phase;
            end
            else
            begin
                half_cnt <= half_cnt + 1'b1;
            end
        end
    end

    // session over, field left visible
    a_ends_visible: assert property (@(posedge CLK) disable iff (!RESETN)
        toggles_done |-> !blink_phase);

endmodule

`default_nettype wire

// ==== logic/screen_composer.sv ====
// Screen buffer composer
`default_nettype none

module screen_composer
(
    input  logic                        CLK,
    input  logic                        RESETN,
    input  clock_lcd_pkg::display_mode_e mode,
    input  clock_lcd_pkg::bcd_digit_t   hour_tens, hour_ones,
    input  clock_lcd_pkg::bcd_digit_t   min_tens, min_ones,
    input  clock_lcd_pkg::bcd_digit_t   sec_tens, sec_ones,
    input  clock_lcd_pkg::bcd_digit_t   year_tens, year_ones,
    input  clock_lcd_pkg::bcd_digit_t   month_tens, month_ones,
    input  clock_lcd_pkg::bcd_digit_t   day_tens, day_ones,
    input  clock_lcd_pkg::bcd_digit_t   alarm_hour_tens, alarm_hour_ones,
    input  clock_lcd_pkg::bcd_digit_t   alarm_min_tens, alarm_min_ones,
    input  clock_lcd_pkg::bcd_digit_t   alarm_sec_tens, alarm_sec_ones,
    input  logic                        alarm_armed,
    input  logic                        alarm_ringing,
    input  logic                        blink_phase,
    input  clock_lcd_pkg::char_index_t  char_index,
    output logic                        editing,
    output logic                        blink_restart,
    output clock_lcd_pkg::lcd_char_t    screen_char
);
    import clock_lcd_pkg::*;

    typedef enum logic [2:0] {
        field_none,
        field_hour,
        field_min,
        field_sec,
        field_year,
        field_month,
        field_day
    } edit_field_e;

    edit_field_e edit_field;
    edit_field_e prev_field;
    logic        is_clock;
    logic        is_alarm;
    logic        edit_glyph;
    logic        blank;
    bcd_digit_t  h_t, h_o, m_t, m_o, s_t, s_o;
    lcd_char_t   screen_d [SCREEN_CHARS];
    lcd_char_t   screen_q [SCREEN_CHARS];

    function automatic lcd_char_t digit_char(input bcd_digit_t d, input logic hide);
        return hide ? CHAR_SPACE : CHAR_ZERO + lcd_char_t'(d);
    endfunction

    assign is_clock = mode inside {clock_view, clock_edit_idle, clock_edit_hour,
                                   clock_edit_min, clock_edit_sec, clock_edit_year,
                                   clock_edit_month, clock_edit_day};
    assign is_alarm = mode inside {alarm_view, alarm_edit_idle, alarm_edit_hour,
                                   alarm_edit_min, alarm_edit_sec};

    always_comb
    begin
        case (mode)
            clock_edit_hour, alarm_edit_hour: edit_field = field_hour;
            clock_edit_min, alarm_edit_min:   edit_field = field_min;
            clock_edit_sec, alarm_edit_sec:   edit_field = field_sec;
            clock_edit_year:                  edit_field = field_year;
            clock_edit_month:                 edit_field = field_month;
            clock_edit_day:                   edit_field = field_day;
            default:                          edit_field = field_none;
        endcase
    end

    assign editing       = (edit_field != field_none);
    assign edit_glyph    = editing || (mode == clock_edit_idle) || (mode == alarm_edit_idle);
    assign blink_restart = editing && (edit_field != prev_field);
    assign blank         = blink_phase && editing;

    // line 1 time source
    assign h_t = is_alarm ? alarm_hour_tens : hour_tens;
    assign h_o = is_alarm ? alarm_hour_ones : hour_ones;
    assign m_t = is_alarm ? alarm_min_tens : min_tens;
    assign m_o = is_alarm ? alarm_min_ones : min_ones;
    assign s_t = is_alarm ? alarm_sec_tens : sec_tens;
    assign s_o = is_alarm ? alarm_sec_ones : sec_ones;

    always_comb
    begin
        for (int i = 0; i < SCREEN_CHARS; i++)
        begin
            screen_d[i] = CHAR_SPACE;
        end
        if (is_clock || is_alarm)
        begin
            screen_d[1]  = digit_char(h_t, blank && edit_field == field_hour);
            screen_d[2]  = digit_char(h_o, blank && edit_field == field_hour);
            screen_d[3]  = CHAR_COLON;
            screen_d[4]  = digit_char(m_t, blank && edit_field == field_min);
            screen_d[5]  = digit_char(m_o, blank && edit_field == field_min);
            screen_d[6]  = CHAR_COLON;
            screen_d[7]  = digit_char(s_t, blank && edit_field == field_sec);
            screen_d[8]  = digit_char(s_o, blank && edit_field == field_sec);
            screen_d[12] = is_alarm ? CHAR_BELL : CHAR_SPACE;
            screen_d[13] = edit_glyph ? CHAR_EDIT : CHAR_SPACE;
            if (is_clock)
            begin
                screen_d[17] = CHAR_TWO;  // century fixed at 20
                screen_d[18] = CHAR_ZERO;
                screen_d[19] = digit_char(year_tens, blank && edit_field == field_year);
                screen_d[20] = digit_char(year_ones, blank && edit_field == field_year);
                screen_d[21] = CHAR_Y;
                screen_d[22] = digit_char(month_tens, blank && edit_field == field_month);
                screen_d[23] = digit_char(month_ones, blank && edit_field == field_month);
                screen_d[24] = CHAR_M;
                screen_d[25] = digit_char(day_tens, blank && edit_field == field_day);
                screen_d[26] = digit_char(day_ones, blank && edit_field == field_day);
                screen_d[27] = CHAR_D;
            end
            screen_d[29] = alarm_ringing ? CHAR_NOTE : CHAR_SPACE;
            screen_d[30] = alarm_armed ? CHAR_BELL : CHAR_SPACE;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (!RESETN)
        begin
            prev_field <= field_none;
            for (int i = 0; i < SCREEN_CHARS; i++)
            begin
                screen_q[i] <= CHAR_SPACE;
            end
        end
        else
        begin
            prev_field <= edit_field;
            screen_q   <= screen_d;  // full rebuild every cycle
        end
    end

    assign screen_char = screen_q[char_index];

    for (genvar g = 0; g < SCREEN_CHARS; g++)
    begin : g_known
        a_entry_known: assert property (@(posedge CLK) disable iff (!RESETN)
            !$isunknown(screen_q[g]));
    end

endmodule

`default_nettype wire

// ==== logic/lcd_sequencer.sv ====
// LCD bus command sequencer
`default_nettype none

module lcd_sequencer
(
    input  logic                       CLK,
    input  logic                       RESETN,
    input  clock_lcd_pkg::lcd_char_t   screen_char,
    output clock_lcd_pkg::char_index_t char_index,
    output logic                       lcd_e,
    output logic                       lcd_rs,
    output logic                       lcd_rw,
    output clock_lcd_pkg::lcd_char_t   lcd_data
);
    import clock_lcd_pkg::*;

    localparam logic [SLOT_W-1:0] SLOT_LAST = SLOT_W'(WRITE_CYCLES - 1);

    lcd_state_e        state;
    lcd_state_e        state_next;
    logic [STEP_W-1:0] step_cnt;
    logic [STEP_W-1:0] step_last;
    logic [SLOT_W-1:0] slot_cnt;
    logic              slot_state;
    logic              tick;
    logic              slot_first;
    logic              slot_second;
    logic              rs_next;
    lcd_char_t         data_next;
    char_index_t       col;

    // refresh states advance per write slot, init states per cycle
    assign slot_state  = (state == line1) || (state == line2) || (state == return_home);
    assign tick        = slot_state ? (slot_cnt == SLOT_LAST) : 1'b1;
    assign slot_first  = slot_state ? (slot_cnt == '0) : (step_cnt == '0);
    assign slot_second = slot_state ? (slot_cnt == SLOT_W'(1)) : (step_cnt == STEP_W'(1));

    assign col        = char_index_t'(step_cnt - 1'b1);  // step 0 is the address
    assign char_index = (state == line2) ? col + char_index_t'(LINE_CHARS) : col;

    always_comb
    begin
        state_next = power_up;
        step_last  = '0;
        rs_next    = 1'b0;
        data_next  = '0;
        case (state)
            power_up:
            begin
                state_next = function_set;
                step_last  = STEP_W'(POWER_UP_CYCLES - 1);
                rs_next    = 1'b1;  // bus held as after reset
            end
            function_set:
            begin
                state_next = display_on;
                step_last  = STEP_W'(COMMAND_CYCLES - 1);
                data_next  = CMD_FUNCTION_SET;
            end
            display_on:
            begin
                state_next = entry_mode;
                step_last  = STEP_W'(COMMAND_CYCLES - 1);
                data_next  = CMD_DISPLAY_ON;
            end
            entry_mode:
            begin
                state_next = line1;
                step_last  = STEP_W'(COMMAND_CYCLES - 1);
                data_next  = CMD_ENTRY_MODE;
            end
            line1:
            begin
                state_next = line2;
                step_last  = STEP_W'(LINE_CHARS);  // address + 16 chars
                rs_next    = (step_cnt != '0);
                data_next  = (step_cnt == '0) ? CMD_LINE1_ADDR : screen_char;
            end
            line2:
            begin
                state_next = return_home;
                step_last  = STEP_W'(LINE_CHARS);
                rs_next    = (step_cnt != '0);
                data_next  = (step_cnt == '0) ? CMD_LINE2_ADDR : screen_char;
            end
            return_home:
            begin
                state_next = line1;
                data_next  = CMD_RETURN_HOME;
            end
            default: ;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (!RESETN)
        begin
            state    <= power_up;
            step_cnt <= '0;
            slot_cnt <= '0;
        end
        else
        begin
            slot_cnt <= (slot_state && slot_cnt != SLOT_LAST) ? slot_cnt + 1'b1 : '0;
            if (tick)
            begin
                if (step_cnt == step_last)
                begin
                    state    <= state_next;
                    step_cnt <= '0;
                end
                else
                begin
                    step_cnt <= step_cnt + 1'b1;
                end
            end
        end
    end

    // data latched at slot start, enable pulses in the next two cycles
    always_ff @(posedge CLK)
    begin
        if (!RESETN)
        begin
            lcd_e    <= 1'b0;
            lcd_rs   <= 1'b1;
            lcd_rw   <= 1'b1;
            lcd_data <= '0;
        end
        else
        begin
            lcd_e  <= (state != power_up) && (slot_first || slot_second);
            lcd_rw <= (state == power_up);  // write only once running
            if (slot_first)
            begin
                lcd_rs   <= rs_next;
                lcd_data <= data_next;
            end
        end
    end

    // rs and data settled across the falling edge of e
    a_data_held_at_strobe: assert property (@(posedge CLK) disable iff (!RESETN)
        $fell(lcd_e) |-> $stable(lcd_rs) && $stable(lcd_data));

endmodule

`default_nettype wire

// ==== logic/clock_lcd_top.sv ====
// Clock LCD front end top
`default_nettype none

module clock_lcd_top
(
    input  logic                         CLK,
    input  logic                         RESETN,
    input  clock_lcd_pkg::display_mode_e mode,
    input  clock_lcd_pkg::bcd_digit_t    hour_tens, hour_ones,
    input  clock_lcd_pkg::bcd_digit_t    min_tens, min_ones,
    input  clock_lcd_pkg::bcd_digit_t    sec_tens, sec_ones,
    input  clock_lcd_pkg::bcd_digit_t    year_tens, year_ones,
    input  clock_lcd_pkg::bcd_digit_t    month_tens, month_ones,
    input  clock_lcd_pkg::bcd_digit_t    day_tens, day_ones,
    input  clock_lcd_pkg::bcd_digit_t    alarm_hour_tens, alarm_hour_ones,
    input  clock_lcd_pkg::bcd_digit_t    alarm_min_tens, alarm_min_ones,
    input  clock_lcd_pkg::bcd_digit_t    alarm_sec_tens, alarm_sec_ones,
    input  logic                         alarm_armed,
    input  logic                         alarm_ringing,
    output logic                         lcd_e,
    output logic                         lcd_rs,
    output logic                         lcd_rw,
    output clock_lcd_pkg::lcd_char_t     lcd_data
);
    import clock_lcd_pkg::*;

    logic        editing;
    logic        blink_restart;
    logic        blink_phase;
    lcd_char_t   screen_char;
    char_index_t char_index;

    field_blinker u_blinker
    (
        .CLK,
        .RESETN,
        .editing,
        .blink_restart,
        .blink_phase
    );

    screen_composer u_composer
    (
        .CLK,
        .RESETN,
        .mode,
        .hour_tens, .hour_ones, .min_tens, .min_ones, .sec_tens, .sec_ones,
        .year_tens, .year_ones, .month_tens, .month_ones, .day_tens, .day_ones,
        .alarm_hour_tens, .alarm_hour_ones,
        .alarm_min_tens, .alarm_min_ones,
        .alarm_sec_tens, .alarm_sec_ones,
        .alarm_armed,
        .alarm_ringing,
        .blink_phase,
        .char_index,
        .editing,
        .blink_restart,
        .screen_char
    );

    lcd_sequencer u_sequencer
    (
        .CLK,
        .RESETN,
        .screen_char,
        .char_index,
        .lcd_e,
        .lcd_rs,
        .lcd_rw,
        .lcd_data
    );

endmodule

`default_nettype wire

// ==== tb/lcd_bus_monitor.sv ====
// LCD bus monitor
`default_nettype none

module lcd_bus_monitor
(
    input  logic                     RESETN,
    input  logic                     lcd_e,
    input  logic                     lcd_rs,
    input  logic                     lcd_rw,
    input  clock_lcd_pkg::lcd_char_t lcd_data,
    output clock_lcd_pkg::lcd_char_t screen [clock_lcd_pkg::SCREEN_CHARS],
    output clock_lcd_pkg::lcd_char_t first_cmds [4],
    output int                       cmd_count,
    output int                       char_count,
    output int                       frame_count
);
    import clock_lcd_pkg::*;

    lcd_char_t   shadow [SCREEN_CHARS] = '{default: CHAR_SPACE};
    lcd_char_t   cmd_log [4] = '{default: 8'h00};
    char_index_t cursor = '0;  // panel address counter
    int          cmds = 0;
    int          chars = 0;
    int          frames = 0;

    // panel latches rs and data on the falling edge of e
    always @(negedge lcd_e)
    begin
        if (RESETN && !lcd_rw)
        begin
            if (lcd_rs)
            begin
                shadow[cursor] = lcd_data;
                cursor         = cursor + 1'b1;  // wraps like the panel
                chars++;
            end
            else
            begin
                if (cmds < 4)
                begin
                    cmd_log[cmds[1:0]] = lcd_data;
                end
                cmds++;
                case (lcd_data)
                    CMD_LINE1_ADDR:  cursor = '0;
                    CMD_LINE2_ADDR:  cursor = char_index_t'(LINE_CHARS);
                    CMD_RETURN_HOME:
                    begin
                        cursor = '0;
                        frames++;  // one full refresh done
                    end
                    default: ;
                endcase
            end
        end
    end

    assign screen      = shadow;
    assign first_cmds  = cmd_log;
    assign cmd_count   = cmds;
    assign char_count  = chars;
    assign frame_count = frames;

endmodule

`default_nettype wire

// ==== tb/tb_clock_lcd.sv ====
// Clock LCD testbench
`default_nettype none

module tb_clock_lcd;
    import clock_lcd_pkg::*;

    localparam int FRAME_CYCLES = (3 + 2 * LINE_CHARS) * WRITE_CYCLES;
    localparam int INIT_TIMEOUT = POWER_UP_CYCLES + 4 * COMMAND_CYCLES + FRAME_CYCLES;
    localparam int BLINK_CYCLES = BLINK_TOGGLES * BLINK_HALF_PERIOD;
    localparam display_mode_e FIELD_MODES [9] = '{clock_edit_hour, clock_edit_min,
        clock_edit_sec, clock_edit_year, clock_edit_month, clock_edit_day,
        alarm_edit_hour, alarm_edit_min, alarm_edit_sec};

    logic          CLK = 1'b0;
    logic          RESETN;
    display_mode_e mode;
    bcd_digit_t    clk_dig [12];  // hour, min, sec, year, month, day, tens first
    bcd_digit_t    alm_dig [6];   // alarm hour, min, sec
    logic          alarm_armed;
    logic          alarm_ringing;
    logic          lcd_e;
    logic          lcd_rs;
    logic          lcd_rw;
    lcd_char_t     lcd_data;
    lcd_char_t     screen_seen [SCREEN_CHARS];
    lcd_char_t     first_cmds [4];
    int            cmd_count;
    int            char_count;
    int            frame_count;
    logic          allow_blink;
    int            check_req = 0;
    int            check_ack = 0;

    always #10 CLK = ~CLK;

    clock_lcd_top uut
    (
        .CLK, .RESETN, .mode,
        .hour_tens(clk_dig[0]), .hour_ones(clk_dig[1]),
        .min_tens(clk_dig[2]), .min_ones(clk_dig[3]),
        .sec_tens(clk_dig[4]), .sec_ones(clk_dig[5]),
        .year_tens(clk_dig[6]), .year_ones(clk_dig[7]),
        .month_tens(clk_dig[8]), .month_ones(clk_dig[9]),
        .day_tens(clk_dig[10]), .day_ones(clk_dig[11]),
        .alarm_hour_tens(alm_dig[0]), .alarm_hour_ones(alm_dig[1]),
        .alarm_min_tens(alm_dig[2]), .alarm_min_ones(alm_dig[3]),
        .alarm_sec_tens(alm_dig[4]), .alarm_sec_ones(alm_dig[5]),
        .alarm_armed, .alarm_ringing,
        .lcd_e, .lcd_rs, .lcd_rw, .lcd_data
    );

    lcd_bus_monitor mon
    (
        .RESETN, .lcd_e, .lcd_rs, .lcd_rw, .lcd_data,
        .screen(screen_seen), .first_cmds, .cmd_count, .char_count, .frame_count
    );

    // expected glyph at one screen position
    function automatic lcd_char_t expected_char(input display_mode_e m, input int pos,
                                                input logic blink);
        logic      clock_side;
        logic      alarm_side;
        logic      marked;
        int        edited;
        int        fld;
        int        idx;
        lcd_char_t c;
        clock_side = 1'b0;
        alarm_side = 1'b0;
        edited     = -1;  // no field under edit
        fld        = 0;
        idx        = 0;
        c          = CHAR_SPACE;
        case (m)
            clock_view, clock_edit_idle, clock_edit_hour, clock_edit_min, clock_edit_sec,
            clock_edit_year, clock_edit_month, clock_edit_day:
                clock_side = 1'b1;
            alarm_view, alarm_edit_idle, alarm_edit_hour, alarm_edit_min, alarm_edit_sec:
                alarm_side = 1'b1;
            default: ;
        endcase
        marked = (clock_side || alarm_side) && m != clock_view && m != alarm_view;
        case (m)
            clock_edit_hour, alarm_edit_hour: edited = 0;
            clock_edit_min, alarm_edit_min:   edited = 1;
            clock_edit_sec, alarm_edit_sec:   edited = 2;
            clock_edit_year:                  edited = 3;
            clock_edit_month:                 edited = 4;
            clock_edit_day:                   edited = 5;
            default: ;
        endcase
        if (clock_side || alarm_side)
        begin
            if (pos >= 1 && pos <= 8 && (pos % 3) != 0)
            begin
                fld = (pos - 1) / 3;  // hh:mm:ss groups of three
                idx = fld * 2 + (pos - 1) % 3;
                c   = CHAR_ZERO + lcd_char_t'(alarm_side ? alm_dig[idx] : clk_dig[idx]);
                if (blink && edited == fld)
                begin
                    c = CHAR_SPACE;
                end
            end
            else if (pos == 3 || pos == 6)
                c = CHAR_COLON;
            else if (pos == 12 && alarm_side)
                c = CHAR_BELL;
            else if (pos == 13 && marked)
                c = CHAR_EDIT;
            else if (clock_side && pos >= 19 && pos <= 26 && ((pos - 19) % 3) != 2)
            begin
                fld = 3 + (pos - 19) / 3;  // yyYmmMddD
                idx = fld * 2 + (pos - 19) % 3;
                c   = (blink && edited == fld) ? CHAR_SPACE
                                               : CHAR_ZERO + lcd_char_t'(clk_dig[idx]);
            end
            else if (clock_side && pos == 17)
                c = CHAR_TWO;
            else if (clock_side && pos == 18)
                c = CHAR_ZERO;
            else if (clock_side && pos == 21)
                c = CHAR_Y;
            else if (clock_side && pos == 24)
                c = CHAR_M;
            else if (clock_side && pos == 27)
                c = CHAR_D;
            else if (pos == 29 && alarm_ringing)
                c = CHAR_NOTE;
            else if (pos == 30 && alarm_armed)
                c = CHAR_BELL;
        end
        return c;
    endfunction

    task automatic compare_values(input logic [31:0] got, input logic [31:0] want,
                                  input string what);
        if (got !== want)
        begin
            $display("FAILED at time %0t: %s is %0h, expected %0h", $time, what, got, want);
            $display("Checks failed");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic check_screen;
        lcd_char_t plain;
        lcd_char_t blanked;
        lcd_char_t want;
        for (int i = 0; i < SCREEN_CHARS; i++)
        begin
            plain   = expected_char(mode, i, 1'b0);
            blanked = expected_char(mode, i, 1'b1);
            want    = (allow_blink && screen_seen[i] == blanked) ? blanked : plain;
            compare_values(32'(screen_seen[i]), 32'(want), $sformatf("screen position %0d", i));
        end
    endtask

    // screen only changes after this edge, so the snapshot is stable here
    always @(posedge CLK)
    begin
        if (check_ack != check_req)
        begin
            check_screen();
            check_ack = check_req;
        end
    end

    task automatic run_check(input logic blink_free);
        int waited;
        allow_blink = blink_free;
        check_req++;
        waited = 0;
        while (check_ack != check_req)
        begin
            @(negedge CLK);
            waited++;
            if (waited > 4)
            begin
                $display("timeout: the screen comparison did not run");
                $display("Checks failed");
                $fatal(1, "comparison timeout");
            end
        end
    endtask

    task automatic wait_frames(input int n);
        int target;
        int waited;
        target = frame_count + n;
        waited = 0;
        while (frame_count < target)
        begin
            @(negedge CLK);
            waited++;
            if (waited > (n + 1) * FRAME_CYCLES)
            begin
                $display("timeout: the LCD did not complete %0d frames in time", n);
                $display("Checks failed");
                $fatal(1, "frame timeout");
            end
        end
    endtask

    task automatic wait_commands(input int n);
        int waited;
        waited = 0;
        while (cmd_count < n)
        begin
            @(negedge CLK);
            waited++;
            if (waited > INIT_TIMEOUT)
            begin
                $display("timeout: the LCD init commands did not appear on the bus");
                $display("Checks failed");
                $fatal(1, "init timeout");
            end
        end
    endtask

    task automatic randomize_inputs;
        for (int i = 0; i < 12; i++)
        begin
            clk_dig[i] = bcd_digit_t'($urandom_range(9, 0));
        end
        for (int i = 0; i < 6; i++)
        begin
            alm_dig[i] = bcd_digit_t'($urandom_range(9, 0));
        end
        alarm_armed   = 1'($urandom_range(1, 0));
        alarm_ringing = 1'($urandom_range(1, 0));
    endtask

    task automatic show_and_check(input display_mode_e m);
        mode = m;
        wait_frames(2);  // first frame may straddle the change
        run_check(1'b0);
    endtask

    initial
    begin
        void'($urandom(32'h6217));
        RESETN        = 1'b0;
        mode          = clock_view;
        alarm_armed   = 1'b0;
        alarm_ringing = 1'b0;
        allow_blink   = 1'b0;
        for (int i = 0; i < 12; i++)
        begin
            clk_dig[i] = '0;
        end
        for (int i = 0; i < 6; i++)
        begin
            alm_dig[i] = '0;
        end
        repeat (3) @(negedge CLK);
        RESETN = 1'b1;

        wait_commands(4);  // three init commands, then the line 1 address
        compare_values(32'(first_cmds[0]), 32'(CMD_FUNCTION_SET), "init command 0");
        compare_values(32'(first_cmds[1]), 32'(CMD_DISPLAY_ON), "init command 1");
        compare_values(32'(first_cmds[2]), 32'(CMD_ENTRY_MODE), "init command 2");
        compare_values(32'(first_cmds[3]), 32'(CMD_LINE1_ADDR), "first refresh command");
        compare_values(char_count, 0, "characters before the first address");
        compare_values(frame_count, 0, "frames before the first address");

        randomize_inputs();
        show_and_check(clock_view);
        randomize_inputs();
        show_and_check(alarm_view);
        show_and_check(alarm_edit_idle);

        for (int k = 0; k < 9; k++)
        begin
            randomize_inputs();
            mode = FIELD_MODES[k];
            repeat (6)
            begin
                wait_frames(2);
                run_check(1'b1);  // edited field may be hidden
            end
            repeat (BLINK_CYCLES) @(negedge CLK);
            wait_frames(2);
            run_check(1'b0);  // blink over, field visible
        end

        show_and_check(display_mode_e'(6'b000111));  // unused mode code
        show_and_check(clock_view);
        randomize_inputs();
        wait_frames(2);
        run_check(1'b0);
        randomize_inputs();
        wait_frames(2);
        run_check(1'b0);

        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
logic/clock_lcd_pkg.sv
logic/field_blinker.sv
logic/screen_composer.sv
logic/lcd_sequencer.sv
logic/clock_lcd_top.sv
tb/lcd_bus_monitor.sv
tb/tb_clock_lcd.sv

// ==== Makefile ====
# Verilator build and run for the clock LCD front end

VERILATOR ?= verilator
TOP       ?= tb_clock_lcd
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -j 0

.PHONY: sim clean

# a $fatal in the testbench gives a non-zero exit status
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
